// File: build.f
hw/lsu_pkg.sv
hw/lsu_decode.sv
hw/lsu_queue.sv
hw/lsu_bus_master.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
dv/wb_slave_model.sv
dv/lsu_tb.sv

// File: Makefile
# Verilator build and run of the LSU testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/lsu_tb.sv
// LSU testbench; all traffic stays inside the 2 KiB model memory, needs a simulator with timing
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int DIR_OPS     = 15 * 30 + 15;          // 15 stores, each read back 30 ways
    localparam int RAND_OPS    = 200;
    localparam int MIS_OPS     = 8;
    localparam int FLUSH_OPS   = 5;
    localparam int TOTAL_OPS   = DIR_OPS + RAND_OPS + MIS_OPS + FLUSH_OPS;
    localparam int MEM_BYTES   = 2048;
    localparam int DRAIN_LIMIT = 200;

    logic        clk_i;
    logic        rstn_i;
    logic        flush;
    mem_op_t     op;
    logic        ready;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    lsu_result_t result;
    logic        empty;
    logic [7:0]  wait_cycles;

    logic [31:0] lfsr;
    logic [7:0]  shadow [MEM_BYTES];                    // Byte image of the bus memory
    lsu_result_t exp_q [$];
    wb_req_t     bus_q [$];
    logic        saw_full;

    lsu_top uut (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .flush_i  (flush),
        .op_i     (op),
        .ready_o  (ready),
        .wb_o     (wb_req),
        .wb_i     (wb_rsp),
        .result_o (result),
        .empty_o  (empty)
    );

    wb_slave_model u_mem (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .wait_i (wait_cycles),
        .wb_i   (wb_req),
        .wb_o   (wb_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    function automatic logic [XLEN_W-1:0] fill_dword(input logic [7:0] i);
        return {~i, i ^ 8'h5a, i, i ^ 8'hc3, ~i, i ^ 8'h96, i, i ^ 8'h3c};
    endfunction

    function automatic int size_bytes(input mem_size_e sz);
        return 1 << int'(sz);
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic lsu_result_t expected_result(input mem_size_e sz, input logic uns,
                                                    input logic [4:0] dest,
                                                    input logic [31:0] addr);
        lsu_result_t r;
        int          n;
        logic        sign;
        n            = size_bytes(sz);
        r.valid      = 1'b1;
        r.rd         = dest;
        r.addr       = addr;
        r.data       = '0;
        r.misaligned = (int'(addr[2:0]) % n) != 0;
        if (!r.misaligned) begin
            for (int k = 0; k < n; k++) begin
                r.data[8*k +: 8] = shadow[int'(addr[10:0]) + k];     // Little endian
            end
            sign = ~uns & r.data[8*n - 1];
            for (int b = 8 * n; b < XLEN_W; b++) begin
                r.data[b] = sign;
            end
        end
        return r;
    endfunction

    function automatic wb_req_t expected_bus(input mem_size_e sz, input logic [31:0] addr,
                                             input logic [63:0] wdata);
        wb_req_t w;
        int      off;
        off   = int'(addr[2:0]);
        w.cyc = 1'b1;
        w.stb = 1'b1;
        w.we  = 1'b1;
        w.adr = {addr[31:3], 3'b000};
        w.sel = '0;
        w.dat = '0;
        for (int k = 0; k < size_bytes(sz); k++) begin
            w.sel[off + k]          = 1'b1;
            w.dat[8*(off + k) +: 8] = wdata[8*k +: 8];
        end
        return w;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_result(input lsu_result_t got, input lsu_result_t exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch at %0t: rd %0d addr %h data %h mis %b, %s",
                                   $time, got.rd, got.addr, got.data, got.misaligned,
                                   $sformatf("expected rd %0d addr %h data %h mis %b",
                                             exp.rd, exp.addr, exp.data, exp.misaligned)));
        end
    endtask

    task automatic check_bus(input wb_req_t got, input wb_req_t exp);
        if (got.adr !== exp.adr || got.sel !== exp.sel || got.dat !== exp.dat) begin
            report_error($sformatf(
                "Mismatch at %0t: store adr %h sel %h dat %h, expected adr %h sel %h dat %h",
                $time, got.adr, got.sel, got.dat, exp.adr, exp.sel, exp.dat));
        end
    endtask

    // Outputs are sampled mid-cycle, each pulse is seen once
    always @(negedge clk_i) begin
        if (rstn_i && result.valid) begin
            if (exp_q.size() == 0) begin
                report_error("A result arrived while no result was expected");
            end else begin
                check_result(result, exp_q.pop_front());
            end
        end
        if (rstn_i && wb_req.cyc && wb_req.stb && wb_req.we && wb_rsp.ack) begin
            if (bus_q.size() == 0) begin
                report_error("A store was acknowledged while no store was expected");
            end else begin
                check_bus(wb_req, bus_q.pop_front());
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * 40) @(posedge clk_i);
        report_error("Timeout: the watchdog expired before the tests finished");
    end

    //////////////////////////////
    // Driving
    //////////////////////////////
    // Called just after a rising edge, returns just after the accepting edge
    task automatic issue_op(input logic st, input mem_size_e sz, input logic uns,
                            input logic [4:0] dest, input logic [31:0] addr,
                            input logic [63:0] wdata);
        logic [63:0] imm_bits;
        logic [63:0] imm;
        logic        mis;
        take_bits(12, imm_bits);
        imm = {{52{imm_bits[11]}}, imm_bits[11:0]};
        op  = '{valid: 1'b1, is_store: st, size: sz, unsigned_ld: uns, rd: dest,
                rs1_data: {32'h0, addr} - imm, imm: imm, rs2_data: wdata};
        while (!ready) begin
            saw_full = 1'b1;
            @(posedge clk_i);
            #1;
        end
        mis = (int'(addr[2:0]) % size_bytes(sz)) != 0;
        if (st && !mis) begin
            bus_q.push_back(expected_bus(sz, addr, wdata));
            for (int k = 0; k < size_bytes(sz); k++) begin
                shadow[int'(addr[10:0]) + k] = wdata[8*k +: 8];
            end
        end else begin
            exp_q.push_back(expected_result(sz, uns, dest, addr));     // Loads and faults
        end
        @(posedge clk_i);
        #1;
        op.valid = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (!(empty && exp_q.size() == 0 && bus_q.size() == 0)) begin
            if (cycles == DRAIN_LIMIT) begin
                report_error("The LSU did not drain its pending operations in time");
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
    endtask

    initial begin
        logic [63:0] bits;
        logic [63:0] data;
        logic [63:0] word;
        logic [31:0] base;
        logic [2:0]  off;
        mem_size_e   sz;
        int          c;
        int          cycles;

        lfsr        = 32'h40cef24a;
        saw_full    = 1'b0;
        rstn_i      = 1'b0;
        flush       = 1'b0;
        op          = '0;
        wait_cycles = 8'd0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            word      = fill_dword(a[10:3]);
            shadow[a] = word[8*a[2:0] +: 8];
        end
        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // Idle outputs after reset
        if (!(ready && empty && !wb_req.cyc && !result.valid)) begin
            report_error($sformatf("Mismatch at %0t: after reset ready %b empty %b cyc %b valid %b",
                                   $time, ready, empty, wb_req.cyc, result.valid));
        end

        // Every store size and offset, read back every way
        c = 0;
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 8; o += (1 << s)) begin
                base = 32'(64 + 8 * c);
                take_bits(64, data);
                issue_op(1'b1, mem_size_e'(s[1:0]), 1'b0, 5'd0, base + 32'(o), data);
                for (int ls = 0; ls < 4; ls++) begin
                    for (int lo = 0; lo < 8; lo += (1 << ls)) begin
                        for (int u = 0; u < 2; u++) begin
                            take_bits(5, bits);
                            issue_op(1'b0, mem_size_e'(ls[1:0]), u[0], bits[4:0],
                                     base + 32'(lo), 64'd0);
                        end
                    end
                end
                c++;
            end
        end
        wait_drained();

        // Random aligned stream with 0 to 3 wait states
        saw_full = 1'b0;
        for (int i = 0; i < RAND_OPS; i++) begin
            take_bits(22, bits);
            take_bits(64, data);
            sz          = mem_size_e'(bits[4:3]);
            off         = bits[21:19] & ~3'(size_bytes(sz) - 1);
            wait_cycles = {6'd0, bits[1:0]};
            issue_op(bits[2], sz, bits[5], bits[10:6], {21'h0, bits[18:11], off}, data);
        end
        wait_drained();
        if (!saw_full) begin
            report_error("ready_o never dropped during the random stream");
        end

        // Misaligned faults, then aligned loads of the same double word
        wait_cycles = 8'd0;
        base        = 32'd1600;
        take_bits(64, data);
        issue_op(1'b0, SIZE_H, 1'b0, 5'd1, base + 32'd1, 64'd0);
        issue_op(1'b0, SIZE_W, 1'b1, 5'd2, base + 32'd2, 64'd0);
        issue_op(1'b0, SIZE_D, 1'b0, 5'd3, base + 32'd4, 64'd0);
        issue_op(1'b1, SIZE_H, 1'b0, 5'd4, base + 32'd3, data);
        issue_op(1'b1, SIZE_W, 1'b0, 5'd5, base + 32'd1, data);
        issue_op(1'b1, SIZE_D, 1'b0, 5'd6, base + 32'd7, data);
        issue_op(1'b0, SIZE_D, 1'b0, 5'd7, base, 64'd0);
        issue_op(1'b0, SIZE_W, 1'b0, 5'd8, base + 32'd4, 64'd0);
        wait_drained();

        // Flush while a load waits on a slow slave
        wait_cycles = 8'd20;
        for (int i = 0; i < 4; i++) begin
            issue_op(1'b0, SIZE_D, 1'b0, 5'(i + 1), 32'(1024 + 8 * i), 64'd0);
        end
        cycles = 0;
        while (!wb_req.cyc) begin
            if (cycles == DRAIN_LIMIT) begin
                report_error("No bus cycle started before the flush");
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
        flush = 1'b1;
        exp_q.delete();                                 // Flushed loads return nothing
        @(posedge clk_i);
        #1;
        flush = 1'b0;
        cycles = 0;
        while (wb_req.cyc) begin                        // Open cycle runs to its ack
            if (empty) begin
                report_error("empty_o rose while the flushed bus cycle was still open");
            end
            if (cycles == DRAIN_LIMIT) begin
                report_error("The flushed bus cycle never ended");
            end
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (!empty) begin
            report_error("empty_o stayed low after the flushed bus cycle ended");
        end
        wait_drained();
        repeat (4) @(posedge clk_i);                    // Two-stage result path settles
        #1;
        wait_cycles = 8'd0;
        issue_op(1'b0, SIZE_D, 1'b0, 5'd9, 32'd1024, 64'd0);
        wait_drained();

        if (exp_q.size() != 0 || bus_q.size() != 0) begin
            report_error("Expected results were left over at the end of the run");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: dv/wb_slave_model.sv
// Wishbone classic memory of 256 double words at adr[10:3]; registered ack comes wait_i cycles late
`timescale 1ns/1ps

module wb_slave_model (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic [7:0]       wait_i,
    input  lsu_pkg::wb_req_t wb_i,
    output lsu_pkg::wb_rsp_t wb_o
);
    import lsu_pkg::*;

    localparam int MEM_DEPTH = 256;

    logic [XLEN_W-1:0] mem [MEM_DEPTH];
    logic [7:0]        idx;
    logic [7:0]        wait_cnt_q;
    logic              ack_q;

    // Every byte of the fill depends on the double-word index
    function automatic logic [XLEN_W-1:0] fill_dword(input logic [7:0] i);
        return {~i, i ^ 8'h5a, i, i ^ 8'hc3, ~i, i ^ 8'h96, i, i ^ 8'h3c};
    endfunction

    assign idx = wb_i.adr[10:3];

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            ack_q      <= 1'b0;
            wait_cnt_q <= '0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= fill_dword(i[7:0]);
            end
        end else if (ack_q) begin
            ack_q      <= 1'b0;                  // Master drops cyc after this edge
            wait_cnt_q <= '0;
            if (wb_i.we) begin
                for (int k = 0; k < SEL_W; k++) begin
                    if (wb_i.sel[k]) begin
                        mem[idx][8*k +: 8] <= wb_i.dat[8*k +: 8];
                    end
                end
            end
        end else if (wb_i.cyc && wb_i.stb) begin
            if (wait_cnt_q >= wait_i) begin
                ack_q <= 1'b1;
            end else begin
                wait_cnt_q <= wait_cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        wb_o.ack = ack_q;
        wb_o.dat = ack_q ? mem[idx] : '0;        // Read data valid with ack only
    end

endmodule

// File: hw/lsu_top.sv
// LSU top; op_i is taken when op_i.valid and ready_o are high, results leave in acceptance order
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,
    input  lsu_pkg::mem_op_t     op_i,
    output logic                 ready_o,
    output lsu_pkg::wb_req_t     wb_o,
    input  lsu_pkg::wb_rsp_t     wb_i,
    output lsu_pkg::lsu_result_t result_o,
    output logic                 empty_o
);
    import lsu_pkg::*;

    lsu_entry_t entry;
    lsu_entry_t head;
    lsu_done_t  done;
    logic       pop;
    logic       queue_empty;

    //////////////////////////////
    // Decode and queue
    //////////////////////////////
    lsu_decode u_decode (
        .op_i    (op_i),
        .entry_o (entry)
    );

    lsu_queue u_queue (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .entry_i (entry),
        .ready_o (ready_o),
        .head_o  (head),
        .pop_i   (pop),
        .empty_o (queue_empty)
    );

    //////////////////////////////
    // Bus and writeback
    //////////////////////////////
    lsu_bus_master u_bus_master (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .head_i        (head),
        .pop_o         (pop),
        .wb_o          (wb_o),
        .wb_i          (wb_i),
        .queue_empty_i (queue_empty),
        .done_o        (done),
        .empty_o       (empty_o)
    );

    lsu_load_align u_load_align (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .done_i   (done),
        .result_o (result_o)
    );

endmodule

// File: hw/lsu_load_align.sv
// Writeback stage, one cycle of latency; fault results carry zero data and no back-pressure exists
`timescale 1ns/1ps

module lsu_load_align (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  lsu_pkg::lsu_done_t   done_i,
    output lsu_pkg::lsu_result_t result_o
);
    import lsu_pkg::*;

    logic [7:0]        data_byte;
    logic [15:0]       data_half;
    logic [31:0]       data_word;
    logic [XLEN_W-1:0] data_ext;
    lsu_result_t       res_q;

    //////////////////////////////
    // Field select by offset
    //////////////////////////////
    assign data_byte = done_i.rdata[{done_i.offset, 3'b000} +: 8];
    assign data_half = done_i.rdata[{done_i.offset[OFFS_W-1:1], 4'b0000} +: 16];
    assign data_word = done_i.rdata[{done_i.offset[OFFS_W-1], 5'b00000} +: 32];

    // Sign or zero extension
    always_comb begin
        case (done_i.size)
            SIZE_B:  data_ext = {{(XLEN_W-8){~done_i.unsigned_ld & data_byte[7]}}, data_byte};
            SIZE_H:  data_ext = {{(XLEN_W-16){~done_i.unsigned_ld & data_half[15]}}, data_half};
            SIZE_W:  data_ext = {{(XLEN_W-32){~done_i.unsigned_ld & data_word[31]}}, data_word};
            default: data_ext = done_i.rdata;
        endcase
    end

    //////////////////////////////
    // Result register
    //////////////////////////////
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            res_q <= '0;
        end else begin
            res_q.valid <= done_i.valid;                // Single-cycle pulse per completion
            if (done_i.valid) begin
                res_q.rd         <= done_i.rd;
                res_q.addr       <= done_i.addr;
                res_q.misaligned <= done_i.misaligned;
                res_q.data       <= done_i.misaligned ? '0 : data_ext;
            end
        end
    end

    assign result_o = res_q;

endmodule

// File: hw/lsu_bus_master.sv
// One Wishbone classic cycle per entry, no pipelining; a cycle cut by flush runs to ack silently
`timescale 1ns/1ps

module lsu_bus_master (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    input  lsu_pkg::lsu_entry_t head_i,
    output logic                pop_o,
    output lsu_pkg::wb_req_t    wb_o,
    input  lsu_pkg::wb_rsp_t    wb_i,
    input  logic                queue_empty_i,
    output lsu_pkg::lsu_done_t  done_o,
    output logic                empty_o
);
    import lsu_pkg::*;

    typedef enum logic {
        IDLE = 1'b0,
        BUS  = 1'b1
    } state_e;

    state_e     state_q;
    lsu_entry_t cur_q;          // Entry currently on the bus
    logic       flushed_q;      // Flush seen while the cycle was open
    logic       start;
    logic       fault;
    logic       ack_load;
    logic       done_set;
    lsu_done_t  done_d;
    lsu_done_t  done_q;

    //////////////////////////////
    // Head handling
    //////////////////////////////
    always_comb begin
        pop_o = 1'b0;
        start = 1'b0;
        fault = 1'b0;
        if (state_q == IDLE && head_i.valid && ~flush_i) begin
            pop_o = 1'b1;
            fault = head_i.misaligned;               // Exception bypass, never reaches the bus
            start = ~head_i.misaligned;
        end
    end

    // Loads report at ack unless a flush hit this cycle
    assign ack_load = (state_q == BUS) & wb_i.ack & ~cur_q.is_store & ~flushed_q & ~flush_i;
    assign done_set = fault | ack_load;

    always_comb begin
        if (fault) begin
            done_d.size        = head_i.size;
            done_d.unsigned_ld = head_i.unsigned_ld;
            done_d.addr        = head_i.addr;
            done_d.rd          = head_i.rd;
            done_d.rdata       = '0;
        end else begin
            done_d.size        = cur_q.size;
            done_d.unsigned_ld = cur_q.unsigned_ld;
            done_d.addr        = cur_q.addr;
            done_d.rd          = cur_q.rd;
            done_d.rdata       = wb_i.dat;
        end
        done_d.valid      = 1'b1;
        done_d.offset     = done_d.addr[OFFS_W-1:0];
        done_d.misaligned = fault;
    end

    //////////////////////////////
    // Control state
    //////////////////////////////
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            state_q   <= IDLE;
            flushed_q <= 1'b0;
            done_q    <= '0;
        end else begin
            if (done_set) begin
                done_q <= done_d;
            end else begin
                done_q.valid <= 1'b0;                   // Payload held, pulse ends
            end
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q   <= BUS;
                        flushed_q <= 1'b0;
                    end
                end
                default: begin
                    if (flush_i) begin
                        flushed_q <= 1'b1;
                    end
                    if (wb_i.ack) begin
                        state_q <= IDLE;                // cyc and stb drop next cycle
                    end
                end
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (start) begin
            cur_q <= head_i;
        end
    end

    // Bus signals stay constant for the whole BUS state
    always_comb begin
        wb_o.cyc = (state_q == BUS);
        wb_o.stb = (state_q == BUS);
        wb_o.we  = cur_q.is_store;
        wb_o.adr = {cur_q.addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
        wb_o.sel = cur_q.sel;
        wb_o.dat = cur_q.wdata;
    end

    assign done_o  = done_q;

    assign empty_o = (state_q == IDLE) & queue_empty_i;

endmodule

// File: hw/lsu_queue.sv
// In-order entry FIFO; pointers wrap naturally, so QUEUE_DEPTH must stay a power of two
`timescale 1ns/1ps

module lsu_queue (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    input  lsu_pkg::lsu_entry_t entry_i,
    output logic                ready_o,
    output lsu_pkg::lsu_entry_t head_o,
    input  logic                pop_i,
    output logic                empty_o
);
    import lsu_pkg::*;

    lsu_entry_t        mem_q [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QCNT_W-1:0] count_q;
    logic              full;
    logic              push;
    logic              pop;

    assign full    = (count_q == QCNT_W'(QUEUE_DEPTH));
    assign empty_o = (count_q == '0);
    assign ready_o = ~full;

    assign push = entry_i.valid & ~full;
    assign pop  = pop_i & ~empty_o;

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (~rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin                 // Drop everything pending
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // Idle or push and pop together
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // Head is valid whenever something is stored
    always_comb begin
        head_o       = mem_q[rd_ptr_q];
        head_o.valid = ~empty_o;
    end

endmodule

// File: hw/lsu_decode.sv
// Purely combinational; address wraps to ADDR_W bits and lanes outside sel carry zero store data
`timescale 1ns/1ps

module lsu_decode (
    input  lsu_pkg::mem_op_t    op_i,
    output lsu_pkg::lsu_entry_t entry_o
);
    import lsu_pkg::*;

    logic [XLEN_W-1:0] eff_addr;
    logic [OFFS_W-1:0] offset;
    logic [SEL_W-1:0]  sel;
    logic [XLEN_W-1:0] shifted;
    logic [XLEN_W-1:0] lane_data;
    logic              misaligned;

    assign eff_addr = op_i.rs1_data + op_i.imm;
    assign offset   = eff_addr[OFFS_W-1:0];

    // Alignment check and lane mask per access size
    always_comb begin
        case (op_i.size)
            SIZE_B: begin
                misaligned = 1'b0;
                sel        = SEL_W'(8'h01) << offset;
            end
            SIZE_H: begin
                misaligned = offset[0];
                sel        = SEL_W'(8'h03) << offset;
            end
            SIZE_W: begin
                misaligned = |offset[1:0];
                sel        = SEL_W'(8'h0f) << offset;
            end
            default: begin                              // Double word
                misaligned = |offset;
                sel        = '1;
            end
        endcase
    end

    assign shifted = op_i.rs2_data << {offset, 3'b000};

    // Clear the unused lanes so upper rs2 bits never reach the bus
    always_comb begin
        for (int i = 0; i < SEL_W; i++) begin
            lane_data[8*i +: 8] = sel[i] ? shifted[8*i +: 8] : 8'h00;
        end
    end

    always_comb begin
        entry_o.valid       = op_i.valid;
        entry_o.is_store    = op_i.is_store;
        entry_o.size        = op_i.size;
        entry_o.unsigned_ld = op_i.unsigned_ld;
        entry_o.rd          = op_i.rd;
        entry_o.addr        = eff_addr[ADDR_W-1:0];
        entry_o.sel         = sel;
        entry_o.wdata       = lane_data;
        entry_o.misaligned  = misaligned;
    end

endmodule

// File: hw/lsu_pkg.sv
// Shared LSU types; 32-bit byte address on a 64-bit data bus, queue depth must be a power of two
package lsu_pkg;

    //////////////////////////////
    // Widths and depths
    //////////////////////////////
    localparam int XLEN_W      = 64;
    localparam int ADDR_W      = 32;
    localparam int SEL_W       = XLEN_W / 8;             // One select per byte lane
    localparam int OFFS_W      = $clog2(SEL_W);          // Byte offset within a double word
    localparam int REG_IDX_W   = 5;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // Access size, encoded as in funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_e;

    //////////////////////////////
    // Operation and queue entry
    //////////////////////////////
    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        mem_size_e            size;
        logic                 unsigned_ld;      // Zero-extend instead of sign-extend
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN_W-1:0]    rs1_data;         // Base address
        logic [XLEN_W-1:0]    imm;              // Already sign-extended offset
        logic [XLEN_W-1:0]    rs2_data;         // Store data, right aligned
    } mem_op_t;

    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        mem_size_e            size;
        logic                 unsigned_ld;
        logic [REG_IDX_W-1:0] rd;
        logic [ADDR_W-1:0]    addr;
        logic [SEL_W-1:0]     sel;
        logic [XLEN_W-1:0]    wdata;            // Placed on its byte lanes
        logic                 misaligned;
    } lsu_entry_t;

    //////////////////////////////
    // Completion and writeback
    //////////////////////////////
    typedef struct packed {
        logic                 valid;
        mem_size_e            size;
        logic                 unsigned_ld;
        logic [OFFS_W-1:0]    offset;
        logic [ADDR_W-1:0]    addr;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN_W-1:0]    rdata;            // Raw bus double word
        logic                 misaligned;
    } lsu_done_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN_W-1:0]    data;
        logic [ADDR_W-1:0]    addr;
        logic                 misaligned;
    } lsu_result_t;

    //////////////////////////////
    // Wishbone classic
    //////////////////////////////
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;              // Double-word aligned byte address
        logic [SEL_W-1:0]  sel;
        logic [XLEN_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [XLEN_W-1:0] dat;
    } wb_rsp_t;

endpackage
